// File: test/motor_testdata.txt
// kind a b c : 1 send byte a, 2 expect response a, 3 measure motor a high b dir c
// 4 withhold credits a, 5 return one credit, 6 wait a cycles expect b queued
// 7 window a cycles, 8 sync to pwm rise of motor a, 0 end
7 14 0 0
1 CC 0 0 1 00 0 0 1 01 0 0
1 DD 0 0 1 00 0 0 1 09 0 0
2 CC 0 0 2 DD 0 0
1 AA 0 0 1 00 0 0 1 04 0 0 2 AA 0 0
3 0 8 1
1 BB 0 0 1 FF 0 0 1 FD 0 0 2 BB 0 0
3 1 6 2
3 0 8 1
1 AA 0 0 1 00 0 0 1 19 0 0 2 AA 0 0
3 0 12 1
1 BB 0 0 1 00 0 0 1 00 0 0 2 BB 0 0
3 1 0 0
8 0 0 0 7 0D 0 0
1 AA 0 0 1 00 0 0 1 02 0 0
3 0 B 1
2 AA 0 0 7 14 0 0 8 0 0 0
3 0 4 1
4 1 0 0
1 CC 0 0 1 00 0 0 1 01 0 0 1 CC 0 0 1 00 0 0 1 01 0 0
1 CC 0 0 1 00 0 0 1 01 0 0 1 CC 0 0 1 00 0 0 1 01 0 0
1 CC 0 0 1 00 0 0 1 01 0 0 1 CC 0 0 1 00 0 0 1 01 0 0
6 1E 4 0
2 CC 0 0 2 CC 0 0 2 CC 0 0 2 CC 0 0
5 0 0 0
6 14 1 0 2 CC 0 0
6 28 0 0
0 0 0 0

// File: all.f
verilog/motor_pkg.sv
verilog/pwm_cfg_if.sv
verilog/motor_cmd_decoder.sv
verilog/motor_channel.sv
verilog/response_tx.sv
verilog/motor_ctrl_top.sv
test/tb_clock_gen.sv
test/motor_ctrl_assertions.sv
test/motor_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the motor controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module motor_ctrl_tb -o motor_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/motor_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: test/motor_ctrl_tb.sv
module motor_ctrl_tb;
    import motor_pkg::*;

    localparam int MEM_WORDS = 512;

    logic                        clk;
    logic                        rst_n;
    logic [BYTE_W-1:0]           cmd_data;
    logic                        cmd_valid;
    logic                        resp_credit;
    logic [BYTE_W-1:0]           resp_data;
    logic                        resp_valid;
    logic [NUM_MOTORS-1:0]       pwm_out;
    logic [NUM_MOTORS*DIR_W-1:0] motor_in;

    logic [15:0]       tdata [0:MEM_WORDS-1];  // Four words per record
    logic [BYTE_W-1:0] rx_q[$];                // Received response bytes
    logic              withhold;
    logic              credit_req;
    int                cycles;
    int                limit;
    int                err_count;

    tb_clock_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    motor_ctrl_top i_dut (
        .clk         (clk),
        .CPU_RESETN  (rst_n),
        .cmd_data    (cmd_data),
        .cmd_valid   (cmd_valid),
        .resp_credit (resp_credit),
        .resp_data   (resp_data),
        .resp_valid  (resp_valid),
        .pwm_out     (pwm_out),
        .motor_in    (motor_in)
    );

    task automatic fail_check(input string msg);
        err_count++;
        $display("[ERROR] %0t: %s", $time, msg);
        $display("Test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_resp(input logic [BYTE_W-1:0] got, input logic [BYTE_W-1:0] exp);
        if (got !== exp) begin
            fail_check($sformatf("response byte %h, expected %h", got, exp));
        end
    endtask

    task automatic check_high(input cmd_payload_u got, input cmd_payload_u exp, input int m);
        if (got.count !== exp.count) begin
            fail_check($sformatf("motor %0d high count %0d, expected %0d",
                                 m, got.count, exp.count));
        end
    endtask

    task automatic check_dir(input logic [DIR_W-1:0] got, input logic [DIR_W-1:0] exp,
                             input int m);
        if (got !== exp) begin
            fail_check($sformatf("motor %0d direction %b, expected %b", m, got, exp));
        end
    endtask

    // One byte per valid pulse, an idle cycle after it
    task automatic send_byte(input logic [BYTE_W-1:0] b);
        @(negedge clk);
        cmd_data  = b;
        cmd_valid = 1'b1;
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    task automatic expect_resp(input logic [BYTE_W-1:0] exp);
        logic [BYTE_W-1:0] got;
        while (rx_q.size() == 0) begin
            @(negedge clk);
        end
        got = rx_q.pop_front();
        check_resp(got, exp);
    endtask

    // Count high samples over a window of clock cycles
    task automatic measure_motor(input int m, input int win, input logic [15:0] exp_high,
                                 input logic [DIR_W-1:0] exp_dir);
        cmd_payload_u high;
        cmd_payload_u exp;
        high.count = '0;
        exp.count  = exp_high;
        for (int k = 0; k < win; k++) begin
            @(negedge clk);
            if (pwm_out[m]) begin
                high.count = high.count + WORD_W'(1);
            end
        end
        check_high(high, exp, m);
        check_dir(motor_in[m*DIR_W +: DIR_W], exp_dir, m);
    endtask

    // Returns on the falling edge right after pwm rises, counter at zero
    task automatic sync_rise(input int m);
        logic prev;
        @(negedge clk);
        prev = pwm_out[m];
        forever begin
            @(negedge clk);
            if (!prev && pwm_out[m]) begin
                break;
            end
            prev = pwm_out[m];
        end
    endtask

    task automatic wait_count(input int n, input int exp_n);
        repeat (n) @(negedge clk);
        if (rx_q.size() != exp_n) begin
            fail_check($sformatf("%0d response bytes queued, expected %0d",
                                 rx_q.size(), exp_n));
        end
    endtask

    // Cycle budget summed over all records
    function automatic int run_budget();
        int total;
        int win;
        total = 200;
        win   = 20;
        for (int r = 0; r < MEM_WORDS / 4; r++) begin
            case (tdata[4*r])
                16'd1:   total += 2;
                16'd2:   total += 100;
                16'd3:   total += win;
                16'd6:   total += int'(tdata[4*r+1]);
                16'd7:   win = int'(tdata[4*r+1]);
                16'd8:   total += 4 * win;
                default: total += 1;
            endcase
        end
        return total;
    endfunction

    // Response monitor and credit return
    always @(negedge clk) begin
        resp_credit = 1'b0;
        if (resp_valid) begin
            rx_q.push_back(resp_data);
            if (!withhold) begin
                resp_credit = 1'b1;
            end
        end
        if (credit_req) begin
            resp_credit = 1'b1;
            credit_req  = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("Timeout: run exceeded %0d cycles", limit);
            $display("Test failed");
            $fatal(1, "watchdog expired");
        end
    end

    initial begin
        int win;
        int r;
        cmd_data    = '0;
        cmd_valid   = 1'b0;
        resp_credit = 1'b0;
        withhold    = 1'b0;
        credit_req  = 1'b0;
        cycles      = 0;
        err_count   = 0;
        win         = 20;
        limit       = 1000000;
        for (int i = 0; i < MEM_WORDS; i++) begin
            tdata[i] = '0;
        end
        $readmemh("test/motor_testdata.txt", tdata);
        if (tdata[0] == 16'd0) begin
            fail_check("test data file is empty or missing");
        end
        limit = run_budget();
        @(posedge rst_n);
        r = 0;
        while (tdata[4*r] != 16'd0) begin
            case (tdata[4*r])
                16'd1: send_byte(tdata[4*r+1][BYTE_W-1:0]);
                16'd2: expect_resp(tdata[4*r+1][BYTE_W-1:0]);
                16'd3: measure_motor(int'(tdata[4*r+1]), win, tdata[4*r+2],
                                     tdata[4*r+3][DIR_W-1:0]);
                16'd4: withhold = tdata[4*r+1][0];
                16'd5: credit_req = 1'b1;
                16'd6: wait_count(int'(tdata[4*r+1]), int'(tdata[4*r+2]));
                16'd7: win = int'(tdata[4*r+1]);
                16'd8: sync_rise(int'(tdata[4*r+1]));
                default: fail_check($sformatf("unknown record kind %0d", tdata[4*r]));
            endcase
            r++;
        end
        if (err_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: test/motor_ctrl_assertions.sv
module motor_ctrl_assertions (
    input logic                                             clk,
    input logic                                             CPU_RESETN,
    input logic                                             resp_valid,
    input logic [motor_pkg::BYTE_W-1:0]                     resp_data,
    input logic                                             resp_credit,
    input logic                                             cfg_ack_req,
    input logic [motor_pkg::BYTE_W-1:0]                     cfg_ack_hdr,
    input logic [motor_pkg::NUM_MOTORS-1:0]                 ch_ack_req,
    input logic [motor_pkg::NUM_MOTORS-1:0]                 pwm_out,
    input logic [motor_pkg::NUM_MOTORS*motor_pkg::DIR_W-1:0] motor_in
);
    import motor_pkg::*;

    logic [CREDIT_W:0] credit_model;  // Host credits as of last cycle
    logic              credit_seen;   // resp_credit of last cycle
    logic [CREDIT_W:0] credit_now;    // Credits the DUT should hold now

    // A byte seen now was sent last cycle, against last cycle's credits
    always_comb begin
        credit_now = credit_model + (CREDIT_W+1)'(credit_seen)
                     - (CREDIT_W+1)'(resp_valid);
        if (credit_now > (CREDIT_W+1)'(RESP_CREDITS)) begin
            credit_now = (CREDIT_W+1)'(RESP_CREDITS);
        end
    end

    always_ff @(posedge clk or negedge CPU_RESETN) begin
        if (!CPU_RESETN) begin
            credit_model <= (CREDIT_W+1)'(RESP_CREDITS);
            credit_seen  <= 1'b0;
        end else begin
            credit_model <= credit_now;
            credit_seen  <= resp_credit;
        end
    end

    // A byte goes out only if the host had a credit left one cycle before
    a_credit_spent: assert property (@(posedge clk) disable iff (!CPU_RESETN)
        resp_valid |-> ((credit_model != '0) || credit_seen))
        else $error("response byte sent without a credit");

    // A held timer acknowledge leaves as the next byte while credits remain
    a_cfg_served: assert property (@(posedge clk) disable iff (!CPU_RESETN)
        (cfg_ack_req && (credit_now != '0)) |=>
            (resp_valid && (resp_data == $past(cfg_ack_hdr))))
        else $error("timer acknowledge not sent with credits left");

    for (genvar i = 0; i < NUM_MOTORS; i++) begin : g_motor
        localparam logic [BYTE_W-1:0] DUTY_HDR = (i == 0) ? HDR_DUTY0 : HDR_DUTY1;

        // Channel acknowledge stays held until its own byte goes out
        a_ch_kept: assert property (@(posedge clk) disable iff (!CPU_RESETN)
            ch_ack_req[i] |=> (ch_ack_req[i] || (resp_valid && (resp_data == DUTY_HDR))))
            else $error("channel %0d acknowledge dropped without a response", i);

        // Never 11, and a high pin always has a direction
        a_dir_legal: assert property (@(posedge clk) disable iff (!CPU_RESETN)
            (motor_in[i*DIR_W +: DIR_W] != 2'b11) &&
            (!pwm_out[i] || (motor_in[i*DIR_W +: DIR_W] != DIR_STOP)))
            else $error("illegal direction code on motor %0d", i);
    end

endmodule

bind motor_ctrl_top motor_ctrl_assertions i_assertions (
    .clk         (clk),
    .CPU_RESETN  (CPU_RESETN),
    .resp_valid  (resp_valid),
    .resp_data   (resp_data),
    .resp_credit (resp_credit),
    .cfg_ack_req (cfg_ack_req),
    .cfg_ack_hdr (cfg_ack_hdr),
    .ch_ack_req  (ch_ack_req),
    .pwm_out     (pwm_out),
    .motor_in    (motor_in)
);

// File: test/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 10 time unit period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;  // Released on a falling edge like the other inputs
    end

endmodule

// File: verilog/motor_ctrl_top.sv
module motor_ctrl_top (
    input  logic                                             clk,
    input  logic                                             CPU_RESETN,
    input  logic [motor_pkg::BYTE_W-1:0]                     cmd_data,
    input  logic                                             cmd_valid,
    input  logic                                             resp_credit,
    output logic [motor_pkg::BYTE_W-1:0]                     resp_data,
    output logic                                             resp_valid,
    output logic [motor_pkg::NUM_MOTORS-1:0]                 pwm_out,
    output logic [motor_pkg::NUM_MOTORS*motor_pkg::DIR_W-1:0] motor_in
);
    import motor_pkg::*;

    pwm_cfg_if cfg_bus ();

    logic                  cfg_ack_req;
    logic [BYTE_W-1:0]     cfg_ack_hdr;
    logic                  cfg_ack_take;
    logic [NUM_MOTORS-1:0] ch_ack_req;
    logic [NUM_MOTORS-1:0] ch_ack_take;

    motor_cmd_decoder u_decoder (
        .clk          (clk),
        .CPU_RESETN   (CPU_RESETN),
        .cmd_data     (cmd_data),
        .cmd_valid    (cmd_valid),
        .cfg          (cfg_bus.decoder),
        .cfg_ack_req  (cfg_ack_req),
        .cfg_ack_hdr  (cfg_ack_hdr),
        .cfg_ack_take (cfg_ack_take)
    );

    // Motor i drives direction bits [i*DIR_W +: DIR_W], motor 1 on top
    for (genvar i = 0; i < NUM_MOTORS; i++) begin : g_channel
        motor_channel u_channel (
            .clk        (clk),
            .CPU_RESETN (CPU_RESETN),
            .cfg        (cfg_bus.channel),
            .duty_wr    (cfg_bus.duty_wr[i]),
            .pwm_out    (pwm_out[i]),
            .dir        (motor_in[i*DIR_W +: DIR_W]),
            .ack_req    (ch_ack_req[i]),
            .ack_take   (ch_ack_take[i])
        );
    end

    response_tx u_response_tx (
        .clk          (clk),
        .CPU_RESETN   (CPU_RESETN),
        .cfg_ack_req  (cfg_ack_req),
        .cfg_ack_hdr  (cfg_ack_hdr),
        .cfg_ack_take (cfg_ack_take),
        .ch_ack_req   (ch_ack_req),
        .ch_ack_take  (ch_ack_take),
        .resp_data    (resp_data),
        .resp_valid   (resp_valid),
        .resp_credit  (resp_credit)
    );

endmodule

// File: verilog/response_tx.sv
module response_tx (
    input  logic                             clk,
    input  logic                             CPU_RESETN,
    input  logic                             cfg_ack_req,
    input  logic [motor_pkg::BYTE_W-1:0]     cfg_ack_hdr,
    output logic                             cfg_ack_take,
    input  logic [motor_pkg::NUM_MOTORS-1:0] ch_ack_req,
    output logic [motor_pkg::NUM_MOTORS-1:0] ch_ack_take,
    output logic [motor_pkg::BYTE_W-1:0]     resp_data,
    output logic                             resp_valid,
    input  logic                             resp_credit
);
    import motor_pkg::*;

    logic [CREDIT_W-1:0] credits;
    logic [CREDIT_W:0]   credits_sum;  // One bit of headroom before the cap
    logic                can_send;
    logic                send;
    logic [BYTE_W-1:0]   sel_hdr;

    // Channel acknowledges echo the duty header of their motor
    function automatic logic [BYTE_W-1:0] ch_hdr(int idx);
        return (idx == 0) ? HDR_DUTY0 : HDR_DUTY1;
    endfunction

    // A credit arriving this cycle can be spent right away
    assign can_send = (credits != '0) || resp_credit;

    // Fixed priority, decoder then channels by index
    always_comb begin
        cfg_ack_take = 1'b0;
        ch_ack_take  = '0;
        sel_hdr      = cfg_ack_hdr;
        send         = 1'b0;
        if (can_send) begin
            if (cfg_ack_req) begin
                cfg_ack_take = 1'b1;
                send         = 1'b1;
            end else begin
                for (int i = 0; i < NUM_MOTORS; i++) begin
                    if (ch_ack_req[i] && !send) begin
                        ch_ack_take[i] = 1'b1;
                        sel_hdr        = ch_hdr(i);
                        send           = 1'b1;
                    end
                end
            end
        end
    end

    assign credits_sum = {1'b0, credits} + (CREDIT_W+1)'(resp_credit)
                         - (CREDIT_W+1)'(send);

    always_ff @(posedge clk or negedge CPU_RESETN) begin
        if (!CPU_RESETN) begin
            credits    <= CREDIT_W'(RESP_CREDITS);
            resp_valid <= 1'b0;
            resp_data  <= '0;
        end else begin
            if (credits_sum > (CREDIT_W+1)'(RESP_CREDITS)) begin
                credits <= CREDIT_W'(RESP_CREDITS);  // Extra credits are ignored
            end else begin
                credits <= credits_sum[CREDIT_W-1:0];
            end
            resp_valid <= send;
            if (send) begin
                resp_data <= sel_hdr;
            end
        end
    end

endmodule

// File: verilog/motor_channel.sv
module motor_channel (
    input  logic                       clk,
    input  logic                       CPU_RESETN,
    pwm_cfg_if.channel                 cfg,
    input  logic                       duty_wr,
    output logic                       pwm_out,
    output logic [motor_pkg::DIR_W-1:0] dir,
    output logic                       ack_req,
    input  logic                       ack_take
);
    import motor_pkg::*;

    logic [WORD_W-1:0] psc_cnt;
    logic [WORD_W-1:0] per_cnt;    // PWM counter, 0..ccr
    logic [WORD_W-1:0] duty_mag;
    logic              psc_wrap;
    logic              per_wrap;
    cmd_payload_u      shadow_duty;
    cmd_payload_u      active_duty;
    logic              shadow_pend; // Shadow waits for the next period

    // Compare with >= so a smaller new limit cannot strand the counters
    assign psc_wrap = (psc_cnt >= cfg.psc);
    assign per_wrap = psc_wrap && (per_cnt >= cfg.ccr);

    always_ff @(posedge clk or negedge CPU_RESETN) begin
        if (!CPU_RESETN) begin
            psc_cnt <= '0;
            per_cnt <= '0;
        end else if (psc_wrap) begin
            psc_cnt <= '0;
            per_cnt <= per_wrap ? '0 : per_cnt + WORD_W'(1);
        end else begin
            psc_cnt <= psc_cnt + WORD_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (duty_wr) begin
            shadow_duty <= cfg.duty;
        end
    end

    always_ff @(posedge clk or negedge CPU_RESETN) begin
        if (!CPU_RESETN) begin
            active_duty <= '0;
            shadow_pend <= 1'b0;
            ack_req     <= 1'b0;
        end else begin
            if (ack_take) begin
                ack_req <= 1'b0;
            end
            // New duty goes live as the counter returns to zero
            if (per_wrap && shadow_pend) begin
                active_duty <= shadow_duty;
                ack_req     <= 1'b1;
            end
            if (duty_wr) begin
                shadow_pend <= 1'b1;
            end else if (per_wrap) begin
                shadow_pend <= 1'b0;
            end
        end
    end

    always_comb begin
        if (active_duty.duty[WORD_W-1]) begin
            duty_mag = -active_duty.count;
        end else begin
            duty_mag = active_duty.count;
        end
    end

    assign pwm_out = (per_cnt < duty_mag);

    always_comb begin
        if (active_duty.count == '0) begin
            dir = DIR_STOP;
        end else if (active_duty.duty[WORD_W-1]) begin
            dir = DIR_REV;
        end else begin
            dir = DIR_FWD;
        end
    end

endmodule

// File: verilog/motor_cmd_decoder.sv
module motor_cmd_decoder (
    input  logic                        clk,
    input  logic                        CPU_RESETN,
    input  logic [motor_pkg::BYTE_W-1:0] cmd_data,
    input  logic                        cmd_valid,
    pwm_cfg_if.decoder                  cfg,
    output logic                        cfg_ack_req,
    output logic [motor_pkg::BYTE_W-1:0] cfg_ack_hdr,
    input  logic                        cfg_ack_take
);
    import motor_pkg::*;

    typedef enum logic [1:0] {
        ST_HDR,
        ST_HI,
        ST_LO
    } rx_state_t;

    rx_state_t         state;
    logic [BYTE_W-1:0] cur_hdr;   // Header of the command being received
    logic [BYTE_W-1:0] hi_byte;
    cmd_payload_u      payload;
    logic              last_byte;
    logic              timer_cmd;

    // Limit a signed duty to +/- lim, compared in one extra bit
    function automatic cmd_payload_u clamp_duty(cmd_payload_u raw, logic [WORD_W-1:0] lim);
        cmd_payload_u      res;
        logic signed [WORD_W:0] val;
        logic signed [WORD_W:0] bound;
        val   = {raw.duty[WORD_W-1], raw.duty};
        bound = {1'b0, lim};
        if (val > bound) begin
            res.count = lim;
        end else if (val < -bound) begin
            res.count = -lim;
        end else begin
            res = raw;
        end
        return res;
    endfunction

    always_comb begin
        payload.count = {hi_byte, cmd_data};  // Valid only with the low byte
    end

    assign last_byte = cmd_valid && (state == ST_LO);
    assign timer_cmd = last_byte && ((cur_hdr == HDR_PSC) || (cur_hdr == HDR_CCR));

    // Header, high byte, low byte
    always_ff @(posedge clk or negedge CPU_RESETN) begin
        if (!CPU_RESETN) begin
            state   <= ST_HDR;
            cur_hdr <= '0;
        end else if (cmd_valid) begin
            case (state)
                ST_HDR: begin
                    // Unknown headers leave the parser waiting
                    if (cmd_data inside {HDR_DUTY0, HDR_DUTY1, HDR_PSC, HDR_CCR}) begin
                        cur_hdr <= cmd_data;
                        state   <= ST_HI;
                    end
                end
                ST_HI:   state <= ST_LO;
                ST_LO:   state <= ST_HDR;
                default: state <= ST_HDR;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid && (state == ST_HI)) begin
            hi_byte <= cmd_data;
        end
        if (last_byte && ((cur_hdr == HDR_DUTY0) || (cur_hdr == HDR_DUTY1))) begin
            cfg.duty <= clamp_duty(payload, cfg.ccr);
        end
    end

    // Timer registers, duty strobes and the timer acknowledge
    always_ff @(posedge clk or negedge CPU_RESETN) begin
        if (!CPU_RESETN) begin
            cfg.psc     <= PSC_DEFAULT;
            cfg.ccr     <= CCR_DEFAULT;
            cfg.duty_wr <= '0;
            cfg_ack_req <= 1'b0;
            cfg_ack_hdr <= '0;
        end else begin
            cfg.duty_wr <= '0;
            if (cfg_ack_take) begin
                cfg_ack_req <= 1'b0;
            end
            if (last_byte) begin
                case (cur_hdr)
                    HDR_DUTY0: cfg.duty_wr[0] <= 1'b1;
                    HDR_DUTY1: cfg.duty_wr[1] <= 1'b1;
                    HDR_PSC:   cfg.psc <= payload.count;
                    HDR_CCR:   cfg.ccr <= payload.count;
                    default:   ;
                endcase
            end
            // A second acknowledge while one is held gets dropped
            if (timer_cmd && (!cfg_ack_req || cfg_ack_take)) begin
                cfg_ack_req <= 1'b1;
                cfg_ack_hdr <= cur_hdr;
            end
        end
    end

endmodule

// File: verilog/pwm_cfg_if.sv
interface pwm_cfg_if;
    import motor_pkg::*;

    logic [WORD_W-1:0]     psc;      // Prescaler terminal count
    logic [WORD_W-1:0]     ccr;      // Period terminal count
    cmd_payload_u          duty;     // Clamped duty, valid with duty_wr
    logic [NUM_MOTORS-1:0] duty_wr;  // One strobe per motor

    // Command side writes everything
    modport decoder (
        output psc,
        output ccr,
        output duty,
        output duty_wr
    );

    // Each channel gets its strobe on a separate port
    modport channel (
        input psc,
        input ccr,
        input duty
    );

endinterface

// File: verilog/motor_pkg.sv
package motor_pkg;

    // Sizes
    localparam int NUM_MOTORS = 2;
    localparam int BYTE_W     = 8;   // Command and response byte
    localparam int WORD_W     = 16;  // Payload word from two data bytes
    localparam int DIR_W      = 2;   // Direction code per motor

    // Command headers
    localparam logic [BYTE_W-1:0] HDR_DUTY0 = 8'hAA;  // Motor 0 duty
    localparam logic [BYTE_W-1:0] HDR_DUTY1 = 8'hBB;  // Motor 1 duty
    localparam logic [BYTE_W-1:0] HDR_PSC   = 8'hCC;  // Prescaler
    localparam logic [BYTE_W-1:0] HDR_CCR   = 8'hDD;  // Period

    // Timer values after reset
    localparam logic [WORD_W-1:0] PSC_DEFAULT = 16'd99;
    localparam logic [WORD_W-1:0] CCR_DEFAULT = 16'd999;

    // Direction codes driven to the H-bridge inputs
    localparam logic [DIR_W-1:0] DIR_FWD  = 2'b01;
    localparam logic [DIR_W-1:0] DIR_REV  = 2'b10;
    localparam logic [DIR_W-1:0] DIR_STOP = 2'b00;

    // Response credits held by the host at start
    localparam int RESP_CREDITS = 4;
    localparam int CREDIT_W     = $clog2(RESP_CREDITS + 1);

    // One payload word, two readings
    // Duty commands see a signed value, timer commands an unsigned count
    typedef union packed {
        logic signed [WORD_W-1:0] duty;
        logic        [WORD_W-1:0] count;
    } cmd_payload_u;

endpackage
